//--- hw/hazard_tracker.sv
// Register owner lists, hazard mask builder and global hazard table
`timescale 1ns/1ps
`default_nettype none

module hazard_tracker (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  vseq_pkg::seq_req_t                         req_i,
  input  logic                                       accept_i,
  input  vseq_pkg::vid_t                             vid_i,
  input  vseq_pkg::vinsn_mask_t                      running_i,
  output vseq_pkg::vinsn_mask_t                      hazard_o,
  output vseq_pkg::vinsn_mask_t [vseq_pkg::NR_VINSN-1:0] hazard_table_o
);

  import vseq_pkg::*;

  // Last instruction that touched a register, valid while it runs
  typedef struct packed {
    vid_t vid;
    logic valid;
  } owner_t;

  ////////////////////
  // Owner lists
  ////////////////////

  owner_t [NR_VREGS-1:0] read_list_d, read_list_q;
  owner_t [NR_VREGS-1:0] write_list_d, write_list_q;

  vinsn_mask_t                hazard_raw;
  vinsn_mask_t [NR_VINSN-1:0] table_d;

  ////////////////////
  // Hazard mask
  ////////////////////

  always_comb begin
    hazard_raw = '0;

    // RAW on the source operands
    if (req_i.use_vs1 && write_list_q[req_i.vs1].valid) begin
      hazard_raw[write_list_q[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && write_list_q[req_i.vs2].valid) begin
      hazard_raw[write_list_q[req_i.vs2].vid] = 1'b1;
    end

    // WAR and WAW only matter for an instruction that writes vd
    if (req_i.use_vd && read_list_q[req_i.vd].valid) begin
      hazard_raw[read_list_q[req_i.vd].vid] = 1'b1;
    end
    if (req_i.use_vd && write_list_q[req_i.vd].valid) begin
      hazard_raw[write_list_q[req_i.vd].vid] = 1'b1;
    end
  end

  // Drop owners that retire at the coming edge
  // The new instruction's own bit never shows up, since it is not yet running
  assign hazard_o = hazard_raw & running_i;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    table_d      = hazard_table_o;

    // Prune entries whose owner is gone after this edge
    for (int v = 0; v < NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    // New instruction takes over its registers
    if (accept_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: vid_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: vid_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: vid_i, valid: 1'b1};
      end
      // Row of the new ID lists what it waits for
      table_d[vid_i] = hazard_o;
    end

    // Retired IDs vanish from every row
    for (int r = 0; r < NR_VINSN; r++) begin
      table_d[r] = table_d[r] & running_i;
    end
  end

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q    <= '0;
      write_list_q   <= '0;
      hazard_table_o <= '0;
    end else begin
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      hazard_table_o <= table_d;
    end
  end

endmodule : hazard_tracker

`default_nettype wire

//--- hw/issue_ctrl.sv
// Issue controller for ID allocation, request acceptance and running set
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  vseq_pkg::seq_req_t                        req_i,
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  input  vseq_pkg::unit_e                           unit_i,
  input  vseq_pkg::unit_mask_t                      unit_room_i,
  input  vseq_pkg::vinsn_mask_t                     hazard_i,
  input  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  output vseq_pkg::issue_t                          issue_o,
  output logic                                      issue_valid_o,
  input  logic                                      issue_ready_i,
  output logic                                      accept_o,
  output vseq_pkg::vid_t                            vid_o,
  output vseq_pkg::vinsn_mask_t                     running_o,
  output logic                                      idle_o
);

  import vseq_pkg::*;

  vinsn_mask_t running_q;
  vinsn_mask_t done_clr;
  vinsn_mask_t set_mask;
  logic        ids_full;
  logic        issue_free;
  issue_t      issue_d;

  ////////////////////
  // ID allocation
  ////////////////////

  // Walk downwards so the lowest free ID wins
  always_comb begin
    vid_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        vid_o = vid_t'(i);
      end
    end
  end

  assign ids_full = &running_q;

  ////////////////////
  // Acceptance
  ////////////////////

  // Output stage can take a new instruction when empty or draining now
  assign issue_free  = !issue_valid_o || issue_ready_i;
  assign req_ready_o = !ids_full && unit_room_i[unit_i] && issue_free;
  assign accept_o    = req_valid_i && req_ready_o;

  ////////////////////
  // Running set
  ////////////////////

  // Each unit retires at most one ID per cycle
  always_comb begin
    done_clr = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (done_i[u].valid) begin
        done_clr[done_i[u].vid] = 1'b1;
      end
    end
  end

  assign set_mask  = accept_o ? (vinsn_mask_t'(1) << vid_o) : '0;
  // Running set as it will be after this edge, also used for pruning
  assign running_o = (running_q & ~done_clr) | set_mask;
  assign idle_o    = ~|running_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_o;
    end
  end

  ////////////////////
  // Issue register
  ////////////////////

  always_comb begin
    issue_d = '{
      op     : req_i.op,
      vd     : req_i.vd,
      vs1    : req_i.vs1,
      vs2    : req_i.vs2,
      use_vd : req_i.use_vd,
      use_vs1: req_i.use_vs1,
      use_vs2: req_i.use_vs2,
      vid    : vid_o,
      unit   : unit_i,
      hazard : hazard_i
    };
  end

  // Valid drops once consumed unless a new instruction replaces it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (accept_o) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Payload only loads on accept, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_o <= issue_d;
    end
  end

endmodule : issue_ctrl

`default_nettype wire

//--- hw/unit_queue_counter.sv
// In-flight instruction counter for one execution unit with a room flag
`timescale 1ns/1ps
`default_nettype none

module unit_queue_counter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vseq_pkg::unit_mask_t unit_sel_i,
  input  logic                 accept_i,
  input  vseq_pkg::unit_done_t done_i,
  output logic                 room_o
);

  import vseq_pkg::*;

  ////////////////////
  // Up and down
  ////////////////////

  qcnt_t count_q;
  logic  own_sel;
  logic  cnt_up;
  logic  cnt_down;

  // The select reaching this instance only carries its own unit bit
  assign own_sel  = |unit_sel_i;

  // Count an accepted instruction headed for this unit
  assign cnt_up   = accept_i & own_sel;
  // The unit retires one instruction per done pulse
  // Never wrap below zero on a stray pulse
  assign cnt_down = done_i.valid & (count_q != '0);

  ////////////////////
  // Count register
  ////////////////////

  // Accept and done in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (cnt_up && !cnt_down) begin
      count_q <= count_q + qcnt_t'(1);
    end else if (cnt_down && !cnt_up) begin
      count_q <= count_q - qcnt_t'(1);
    end
  end

  // Room while below the depth
  // A full unit frees a slot only after its done edge
  assign room_o = (count_q < qcnt_t'(QUEUE_DEPTH));

endmodule : unit_queue_counter

`default_nettype wire

//--- hw/vector_sequencer.sv
// Vector sequencer top tying decoder, unit counters, hazard tracker and issue
`timescale 1ns/1ps
`default_nettype none

module vector_sequencer (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  vseq_pkg::seq_req_t                            req_i,
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  output vseq_pkg::issue_t                              issue_o,
  output logic                                          issue_valid_o,
  input  logic                                          issue_ready_i,
  input  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  output vseq_pkg::vinsn_mask_t [vseq_pkg::NR_VINSN-1:0] hazard_table_o,
  output logic                                          idle_o
);

  import vseq_pkg::*;

  unit_e       unit;
  unit_mask_t  unit_sel;
  unit_mask_t  unit_room;
  vinsn_mask_t hazard;
  vinsn_mask_t running_next;
  logic        accept;
  vid_t        vid;

  ////////////////////
  // Decode
  ////////////////////

  vinsn_decoder vinsn_decoder_i (
    .op_i      (req_i.op),
    .unit_o    (unit),
    .unit_sel_o(unit_sel)
  );

  ////////////////////
  // Unit counters
  ////////////////////

  // One counter per unit, each fed only its own select bit and done port
  for (genvar i = 0; i < NR_UNITS; i++) begin : gen_unit_cnt
    unit_mask_t own_sel;

    assign own_sel = unit_sel & (unit_mask_t'(1) << i);

    unit_queue_counter unit_queue_counter_i (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .unit_sel_i(own_sel),
      .accept_i  (accept),
      .done_i    (done_i[i]),
      .room_o    (unit_room[i])
    );
  end

  ////////////////////
  // Hazards
  ////////////////////

  hazard_tracker hazard_tracker_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .accept_i      (accept),
    .vid_i         (vid),
    .running_i     (running_next),
    .hazard_o      (hazard),
    .hazard_table_o(hazard_table_o)
  );

  ////////////////////
  // Issue
  ////////////////////

  issue_ctrl issue_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .unit_i       (unit),
    .unit_room_i  (unit_room),
    .hazard_i     (hazard),
    .done_i       (done_i),
    .issue_o      (issue_o),
    .issue_valid_o(issue_valid_o),
    .issue_ready_i(issue_ready_i),
    .accept_o     (accept),
    .vid_o        (vid),
    .running_o    (running_next),
    .idle_o       (idle_o)
  );

endmodule : vector_sequencer

`default_nettype wire

//--- hw/vinsn_decoder.sv
// Instruction decoder that maps an operation onto its execution unit
`timescale 1ns/1ps
`default_nettype none

module vinsn_decoder (
  input  vseq_pkg::vinsn_op_e  op_i,
  output vseq_pkg::unit_e      unit_o,
  output vseq_pkg::unit_mask_t unit_sel_o
);

  import vseq_pkg::*;

  ////////////////////
  // Unit decode
  ////////////////////

  // Every unit is a single processing element, so one op goes to exactly one unit
  always_comb begin
    unique case (op_i)
      // Integer add and subtract share the ALU
      OP_ADD,
      OP_SUB: begin
        unit_o = UNIT_ALU;
      end
      OP_MUL: begin
        unit_o = UNIT_MUL;
      end
      OP_LOAD: begin
        unit_o = UNIT_LOAD;
      end
      // Stores take their data from vs1 and write no register
      OP_STORE: begin
        unit_o = UNIT_STORE;
      end
      // Unused encodings fall back to the ALU
      default: begin
        unit_o = UNIT_ALU;
      end
    endcase
  end

  ////////////////////
  // One-hot select
  ////////////////////

  // Unit enum values are bit indices, so the select follows from one shift
  // Every counter sees this select and keeps its own bit
  assign unit_sel_o = unit_mask_t'(1) << unit_o;

endmodule : vinsn_decoder

`default_nettype wire

//--- hw/vseq_pkg.sv
// Vector sequencer package with the shared constants, types and port structs
`default_nettype none

package vseq_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Instructions that may be in flight at once
  localparam int unsigned NR_VINSN    = 8;
  // Architectural vector registers
  localparam int unsigned NR_VREGS    = 32;
  // ALU, multiplier, load and store
  localparam int unsigned NR_UNITS    = 4;
  // Largest in-flight count per unit, the same for every unit
  localparam int unsigned QUEUE_DEPTH = 2;

  ////////////////////
  // Vector types
  ////////////////////

  // Instruction ID
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  // One bit per instruction ID
  typedef logic [NR_VINSN-1:0] vinsn_mask_t;
  // Vector register number
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  // One bit per execution unit
  typedef logic [NR_UNITS-1:0] unit_mask_t;
  // Queue count, holds 0 up to QUEUE_DEPTH
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] qcnt_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_MUL   = 3'd2,
    OP_LOAD  = 3'd3,
    OP_STORE = 3'd4
  } vinsn_op_e;

  // Each value doubles as the unit's bit index in a unit_mask_t
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  ////////////////////
  // Port structs
  ////////////////////

  // Instruction as it arrives from the dispatcher
  typedef struct packed {
    vinsn_op_e op;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    logic      use_vd;
    logic      use_vs1;
    logic      use_vs2;
  } seq_req_t;

  // Instruction as it leaves for the execution units
  typedef struct packed {
    vinsn_op_e   op;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
    vid_t        vid;
    unit_e       unit;
    vinsn_mask_t hazard;
  } issue_t;

  // Completion pulse from one unit
  typedef struct packed {
    logic valid;
    vid_t vid;
  } unit_done_t;

endpackage : vseq_pkg

`default_nettype wire

//--- project.f
hw/vseq_pkg.sv
hw/vinsn_decoder.sv
hw/unit_queue_counter.sv
hw/hazard_tracker.sv
hw/issue_ctrl.sv
hw/vector_sequencer.sv
sim/vector_sequencer_sva.sv
sim/tb_vector_sequencer.sv

//--- run.sh
#!/bin/sh
# Build and run the vector sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_vector_sequencer \
  --Mdir obj_dir \
  -o tb_vector_sequencer

status=0
./obj_dir/tb_vector_sequencer > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"

//--- sim/tb_vector_sequencer.sv
// Directed testbench for the vector sequencer covering issue, hazards and queue limits
`timescale 1ns/1ps
`default_nettype none

module tb_vector_sequencer;

  import vseq_pkg::*;

  localparam int unsigned CLK_HALF   = 4;
  localparam int unsigned NR_TESTS   = 6;
  localparam int unsigned WAIT_LIMIT = 50;
  localparam int unsigned SEED       = 40659;

  logic                       clk_i;
  logic                       rst_ni;
  seq_req_t                   req_i;
  logic                       req_valid_i;
  logic                       req_ready_o;
  issue_t                     issue_o;
  logic                       issue_valid_o;
  logic                       issue_ready_i;
  unit_done_t  [NR_UNITS-1:0] done_i;
  vinsn_mask_t [NR_VINSN-1:0] hazard_table_o;
  logic                       idle_o;

  int unsigned         err_cnt;
  int unsigned         test_err_base;
  int unsigned         tests_ok;
  // Registers already handed out by the random picker
  logic [NR_VREGS-1:0] reg_taken;

  vector_sequencer vector_sequencer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .done_i        (done_i),
    .hazard_table_o(hazard_table_o),
    .idle_o        (idle_o)
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial clk_i = 1'b0;
  always #CLK_HALF clk_i = ~clk_i;

  // 200 cycles per test
  initial begin
    #(200 * NR_TESTS * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles", 200 * NR_TESTS);
    $display("tests failed");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_issue(input string name, input issue_t exp, input issue_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_mask(input string name, input vinsn_mask_t exp, input vinsn_mask_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Loads write vd only, stores read vs1 only, arithmetic uses all three
  function automatic seq_req_t build_req(vinsn_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2);
    seq_req_t req;
    req.op      = op;
    req.vd      = vd;
    req.vs1     = vs1;
    req.vs2     = vs2;
    req.use_vd  = (op != OP_STORE);
    req.use_vs1 = (op != OP_LOAD);
    req.use_vs2 = (op != OP_LOAD) && (op != OP_STORE);
    return req;
  endfunction

  function automatic unit_e unit_of(vinsn_op_e op);
    case (op)
      OP_MUL:   return UNIT_MUL;
      OP_LOAD:  return UNIT_LOAD;
      OP_STORE: return UNIT_STORE;
      default:  return UNIT_ALU;
    endcase
  endfunction

  function automatic issue_t expect_issue(seq_req_t req, vid_t vid, vinsn_mask_t hazard);
    return issue_t'{op: req.op, vd: req.vd, vs1: req.vs1, vs2: req.vs2,
                    use_vd: req.use_vd, use_vs1: req.use_vs1, use_vs2: req.use_vs2,
                    vid: vid, unit: unit_of(req.op), hazard: hazard};
  endfunction

  task automatic pick_reg(output vreg_t r);
    r = vreg_t'($urandom_range(NR_VREGS - 1, 0));
    while (reg_taken[r]) begin
      r = vreg_t'($urandom_range(NR_VREGS - 1, 0));
    end
    reg_taken[r] = 1'b1;
  endtask

  // Entered and left 1 ns after a rising edge, the last edge being the accept edge
  task automatic send(input seq_req_t req);
    int unsigned waited;
    logic        taken;
    waited      = 0;
    taken       = 1'b0;
    req_i       = req;
    req_valid_i = 1'b1;
    while (!taken && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
    end
    req_valid_i = 1'b0;
    if (!taken) begin
      $display("Request with op %s was not accepted within %0d cycles", req.op.name(),
               WAIT_LIMIT);
      err_cnt++;
    end
  endtask

  // Issue register and table row are checked one cycle after acceptance
  task automatic send_check(input seq_req_t req, input vid_t vid, input vinsn_mask_t hazard);
    send(req);
    check_bit("issue_valid_o", 1'b1, issue_valid_o);
    check_issue("issue_o", expect_issue(req, vid, hazard), issue_o);
    check_mask($sformatf("hazard_table_o[%0d]", vid), hazard, hazard_table_o[vid]);
  endtask

  // Request stays offered and must be refused every cycle
  task automatic expect_stall(input seq_req_t req, input int unsigned cycles);
    req_i       = req;
    req_valid_i = 1'b1;
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("req_ready_o", 1'b0, req_ready_o);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic retire(input unit_e unit, input vid_t vid);
    done_i[unit] = unit_done_t'{valid: 1'b1, vid: vid};
    @(posedge clk_i);
    #1;
    done_i = '0;
  endtask

  task automatic check_all_clear();
    check_bit("idle_o", 1'b1, idle_o);
    for (int r = 0; r < NR_VINSN; r++) begin
      check_mask($sformatf("hazard_table_o[%0d]", r), '0, hazard_table_o[r]);
    end
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_base) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_independent();
    vinsn_op_e ops [4];
    seq_req_t  req;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    ops       = '{OP_ADD, OP_MUL, OP_LOAD, OP_STORE};
    reg_taken = '0;
    // Distinct registers everywhere, so no hazard at all
    for (int i = 0; i < 4; i++) begin
      pick_reg(vd);
      pick_reg(vs1);
      pick_reg(vs2);
      req = build_req(ops[i], vd, vs1, vs2);
      send_check(req, vid_t'(i), '0);
    end
    // One done pulse per unit in the same cycle
    done_i[UNIT_ALU]   = unit_done_t'{valid: 1'b1, vid: 3'd0};
    done_i[UNIT_MUL]   = unit_done_t'{valid: 1'b1, vid: 3'd1};
    done_i[UNIT_LOAD]  = unit_done_t'{valid: 1'b1, vid: 3'd2};
    done_i[UNIT_STORE] = unit_done_t'{valid: 1'b1, vid: 3'd3};
    @(posedge clk_i);
    #1;
    done_i = '0;
    check_all_clear();
    finish_test("independent units");
  endtask

  task automatic test_raw();
    seq_req_t load;
    seq_req_t add;
    load = build_req(OP_LOAD, 5'd5, 5'd0, 5'd0);
    add  = build_req(OP_ADD, 5'd6, 5'd5, 5'd7);
    send_check(load, 3'd0, 8'h00);
    // ADD reads v5, written by the load in ID 0
    send_check(add, 3'd1, 8'h01);
    retire(UNIT_LOAD, 3'd0);
    check_mask("hazard_table_o[1]", 8'h00, hazard_table_o[1]);
    retire(UNIT_ALU, 3'd1);
    check_all_clear();
    finish_test("read after write");
  endtask

  task automatic test_war_waw();
    seq_req_t load;
    seq_req_t store;
    seq_req_t add;
    load  = build_req(OP_LOAD, 5'd10, 5'd0, 5'd0);
    store = build_req(OP_STORE, 5'd0, 5'd10, 5'd0);
    add   = build_req(OP_ADD, 5'd10, 5'd11, 5'd12);
    send_check(load, 3'd0, 8'h00);
    send_check(store, 3'd1, 8'h01);
    // WAR on the store in ID 1, WAW on the load in ID 0
    send_check(add, 3'd2, 8'h03);
    done_i[UNIT_LOAD]  = unit_done_t'{valid: 1'b1, vid: 3'd0};
    done_i[UNIT_STORE] = unit_done_t'{valid: 1'b1, vid: 3'd1};
    done_i[UNIT_ALU]   = unit_done_t'{valid: 1'b1, vid: 3'd2};
    @(posedge clk_i);
    #1;
    done_i = '0;
    check_all_clear();
    finish_test("write after read and write");
  endtask

  task automatic test_queue_limit();
    seq_req_t mul_a;
    seq_req_t mul_b;
    seq_req_t mul_c;
    mul_a = build_req(OP_MUL, 5'd1, 5'd2, 5'd3);
    mul_b = build_req(OP_MUL, 5'd4, 5'd5, 5'd6);
    mul_c = build_req(OP_MUL, 5'd7, 5'd8, 5'd9);
    send_check(mul_a, 3'd0, 8'h00);
    send_check(mul_b, 3'd1, 8'h00);
    // Multiplier queue is full at two
    expect_stall(mul_c, 3);
    retire(UNIT_MUL, 3'd0);
    // ID 0 is free again after its done edge
    send_check(mul_c, 3'd0, 8'h00);
    retire(UNIT_MUL, 3'd1);
    retire(UNIT_MUL, 3'd0);
    check_all_clear();
    finish_test("queue limit");
  endtask

  task automatic test_id_reuse();
    seq_req_t add;
    seq_req_t load;
    seq_req_t sub;
    add  = build_req(OP_ADD, 5'd20, 5'd21, 5'd22);
    load = build_req(OP_LOAD, 5'd23, 5'd0, 5'd0);
    sub  = build_req(OP_SUB, 5'd24, 5'd25, 5'd26);
    send_check(add, 3'd0, 8'h00);
    send_check(load, 3'd1, 8'h00);
    check_bit("idle_o", 1'b0, idle_o);
    retire(UNIT_ALU, 3'd0);
    check_bit("idle_o", 1'b0, idle_o);
    retire(UNIT_LOAD, 3'd1);
    check_bit("idle_o", 1'b1, idle_o);
    send_check(sub, 3'd0, 8'h00);
    retire(UNIT_ALU, 3'd0);
    check_all_clear();
    finish_test("id reuse and idle");
  endtask

  task automatic test_backpressure();
    seq_req_t add;
    seq_req_t sub;
    add = build_req(OP_ADD, 5'd13, 5'd14, 5'd15);
    sub = build_req(OP_SUB, 5'd16, 5'd17, 5'd18);
    issue_ready_i = 1'b0;
    send_check(add, 3'd0, 8'h00);
    expect_stall(sub, 3);
    // Pending issue still held after the stall
    check_bit("issue_valid_o", 1'b1, issue_valid_o);
    check_issue("issue_o", expect_issue(add, 3'd0, 8'h00), issue_o);
    issue_ready_i = 1'b1;
    send_check(sub, 3'd1, 8'h00);
    retire(UNIT_ALU, 3'd0);
    retire(UNIT_ALU, 3'd1);
    check_all_clear();
    finish_test("back-pressure");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(SEED));
    err_cnt       = 0;
    test_err_base = 0;
    tests_ok      = 0;
    reg_taken     = '0;
    rst_ni        = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    issue_ready_i = 1'b1;
    done_i        = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_bit("idle_o", 1'b1, idle_o);
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    test_independent();
    test_raw();
    test_war_waw();
    test_queue_limit();
    test_id_reuse();
    test_backpressure();
    $display("%0d of %0d tests ok, %0d errors", tests_ok, NR_TESTS, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_vector_sequencer

`default_nettype wire

//--- sim/vector_sequencer_sva.sv
// Handshake and reset assertions bound onto the vector sequencer
`timescale 1ns/1ps
`default_nettype none

module vector_sequencer_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input vseq_pkg::issue_t issue_o,
  input logic             issue_valid_o,
  input logic             issue_ready_i,
  input logic             idle_o
);

  // Stalled issue keeps its payload
  issue_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i |=> $stable(issue_o))
    else $error("issue_o changed while the issue was stalled");

  // First edge out of reset sees an empty issue stage
  reset_valid_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !issue_valid_o)
    else $error("issue_valid_o high right after reset");

  // A pending issue always has a running instruction behind it
  idle_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> !idle_o)
    else $error("idle_o high while an issue is pending");

endmodule : vector_sequencer_sva

bind vector_sequencer vector_sequencer_sva vector_sequencer_sva_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .issue_o      (issue_o),
  .issue_valid_o(issue_valid_o),
  .issue_ready_i(issue_ready_i),
  .idle_o       (idle_o)
);

`default_nettype wire
